/* Bender.yml */
package:
  name: aes_cipher_core

sources:
  - include_dirs:
      - .
    files:
      - verilog/aes_pkg.sv
      - verilog/aes_round_sequencer.sv
      - verilog/aes_round_datapath.sv
      - verilog/aes_result_buffer.sv
      - verilog/aes_cipher_core.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb/aes_cipher_core_tb.sv

/* aes_cipher_core.f */
+incdir+.
verilog/aes_pkg.sv
verilog/aes_round_sequencer.sv
verilog/aes_round_datapath.sv
verilog/aes_result_buffer.sv
verilog/aes_cipher_core.sv
tb/aes_cipher_core_tb.sv

/* aes_cipher_core_settings.svh */
// Build-time sizing for the AES-128 cipher core.
// Included by the type package and by any RTL file that needs the round
// count or the result buffer sizing.

`ifndef AES_CIPHER_CORE_SETTINGS_SVH
`define AES_CIPHER_CORE_SETTINGS_SVH

// Fixed by AES-128
`define AES_BLOCK_BITS 128
`define AES_ROUNDS 10

// Ciphertext slots in the result buffer
`define AES_RESULT_DEPTH 2

// Credits the consumer holds after reset
// Never more than AES_RESULT_DEPTH
`define AES_OUT_CREDITS 2

`endif

/* tb/aes_cipher_core_tb.sv */
// Testbench for the AES-128 cipher core.
// Runs the FIPS-197 and all-zero vectors one block at a time, checking the
// round key requests, in_ready, the output latency and the ciphertexts.
// Then it submits blocks back to back with credits withheld until both
// result slots are full, and returns credits after random delays.
// Round keys are expanded here and registered from round_num on each edge.

`timescale 1ns/1ps

`include "aes_cipher_core_settings.svh"

module aes_cipher_core_tb;
    import aes_pkg::*;

    localparam int num_vectors     = 3;
    localparam int reset_cycles    = 16;
    localparam int watchdog_cycles = num_vectors * 3 * 40;
    localparam int last_latency    = `AES_ROUNDS + 2;

    typedef struct packed {
        aes_block_t pt;
        aes_block_t key;
        aes_block_t ct;
    } vector_t;

    logic         clk;
    logic         reset_n;
    logic         start;
    aes_block_t   plaintext;
    logic         in_ready;
    round_index_t round_num;
    aes_block_t   round_key;
    aes_block_t   ciphertext;
    logic         out_valid;
    logic         credit_return;

    vector_t      vec_table [num_vectors];
    aes_block_t   key_sched [num_vectors][`AES_ROUNDS+1];
    aes_block_t   exp_queue [$];
    int           drive_vec;
    int           key_vec;
    int           rx_count;
    int           rx_base;
    int           model_credits;
    int           checks;
    int           errors;
    logic [31:0]  lfsr;

    aes_cipher_core dut_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .start         (start),
        .plaintext     (plaintext),
        .in_ready      (in_ready),
        .round_num     (round_num),
        .round_key     (round_key),
        .ciphertext    (ciphertext),
        .out_valid     (out_valid),
        .credit_return (credit_return)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // FIPS-197 key schedule with word 0 in the top bits of the key
    function automatic aes_block_t expand_key(input aes_block_t key, input int round);
        logic [31:0] w [44];
        logic [31:0] t;
        logic [7:0]  rcon;
        rcon = 8'h01;
        for (int i = 0; i < 4; i++)
        begin
            w[i] = key[127 - 32*i -: 32];
        end
        for (int i = 4; i < 44; i++)
        begin
            t = w[i-1];
            if (i % 4 == 0)
            begin
                t = {t[23:0], t[31:24]};
                t = {sbox_table[t[31:24]], sbox_table[t[23:16]],
                     sbox_table[t[15:8]], sbox_table[t[7:0]]};
                t[31:24] = t[31:24] ^ rcon;
                rcon = {rcon[6:0], 1'b0} ^ (rcon[7] ? 8'h1b : 8'h00);
            end
            w[i] = w[i-4] ^ t;
        end
        return {w[4*round], w[4*round+1], w[4*round+2], w[4*round+3]};
    endfunction

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_random(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++)
        begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    task automatic check_block(input string name, input aes_block_t exp,
                               input aes_block_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_round(input string name, input round_index_t exp,
                               input round_index_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // Holds start until in_ready and returns at the acceptance edge
    task automatic submit_block(input int idx);
        start     <= 1'b1;
        plaintext <= vec_table[idx].pt;
        drive_vec <= idx;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
        start <= 1'b0;
        exp_queue.push_back(vec_table[idx].ct);
    endtask

    task automatic return_credit();
        int delay;
        take_random(3, delay);
        repeat (delay) @(posedge clk);
        credit_return <= 1'b1;
        @(posedge clk);
        credit_return <= 1'b0;
    endtask

    // Caller side key store that follows the request by one edge
    always @(posedge clk)
    begin
        if (start && in_ready)
            key_vec <= drive_vec;
        round_key <= key_sched[key_vec][round_num];
    end

    // Consumer checks order and values and tracks the credits it holds
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (out_valid)
            begin
                check_flag("credit held at strobe", 1'b1, model_credits > 0);
                if (exp_queue.size() == 0)
                begin
                    errors++;
                    $display("out_valid strobe seen with no block outstanding");
                end
                else
                    check_block($sformatf("ciphertext %0d", rx_count),
                                exp_queue.pop_front(), ciphertext);
                rx_count++;
            end
            model_credits = model_credits + int'(credit_return) - int'(out_valid);
        end
    end

    initial
    begin
        repeat (reset_cycles + watchdog_cycles) @(posedge clk);
        $display("Timeout: test sequence not done after %0d cycles", watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        lfsr          = 32'h62414f93;
        reset_n       = 1'b0;
        start         = 1'b0;
        plaintext     = '0;
        round_key     = '0;
        credit_return = 1'b0;
        drive_vec     = 0;
        key_vec       = 0;
        rx_count      = 0;
        model_credits = `AES_OUT_CREDITS;
        checks        = 0;
        errors        = 0;

        // FIPS-197 appendix B and C.1 plus the all-zero key and block
        vec_table[0] = '{128'h3243f6a8885a308d313198a2e0370734,
                         128'h2b7e151628aed2a6abf7158809cf4f3c,
                         128'h3925841d02dc09fbdc118597196a0b32};
        vec_table[1] = '{128'h00112233445566778899aabbccddeeff,
                         128'h000102030405060708090a0b0c0d0e0f,
                         128'h69c4e0d86a7b0430d8cdb78070b4c55a};
        vec_table[2] = '{128'h0, 128'h0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e};
        for (int v = 0; v < num_vectors; v++)
        begin
            for (int k = 0; k <= `AES_ROUNDS; k++)
            begin
                key_sched[v][k] = expand_key(vec_table[v].key, k);
            end
        end

        repeat (reset_cycles) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_flag("out_valid after reset", 1'b0, out_valid);
        check_flag("in_ready after reset", 1'b1, in_ready);
        check_round("round_num after reset", '0, round_num);
        @(posedge clk);

        // One block at a time with credit always available
        for (int v = 0; v < num_vectors; v++)
        begin
            submit_block(v);
            for (int k = 0; k <= last_latency; k++)
            begin
                @(negedge clk);
                if (k <= `AES_ROUNDS)
                begin
                    check_round("round_num sequence", round_index_t'(k), round_num);
                    check_flag("in_ready during rounds", 1'b0, in_ready);
                end
                else if (k == `AES_ROUNDS + 1)
                    check_flag("in_ready after final round", 1'b1, in_ready);
                check_flag("out_valid latency", k == last_latency, out_valid);
                @(posedge clk);
            end
            return_credit();
        end

        // With credits withheld the last two blocks fill both result slots
        rx_base = rx_count;
        submit_block(0);
        submit_block(1);
        submit_block(2);
        submit_block(0);
        repeat (last_latency + 2) @(posedge clk);
        for (int k = 0; k < 8; k++)
        begin
            @(negedge clk);
            check_flag("in_ready with no free slot", 1'b0, in_ready);
            check_flag("out_valid with no credit", 1'b0, out_valid);
            @(posedge clk);
        end
        check_count("strobes with credits withheld", 2, rx_count - rx_base);
        return_credit();
        return_credit();
        while (rx_count < rx_base + 4)
            @(posedge clk);
        @(negedge clk);
        check_flag("in_ready after credits return", 1'b1, in_ready);
        check_flag("out_valid after last ciphertext", 1'b0, out_valid);
        @(posedge clk);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* verilog/aes_cipher_core.sv */
// AES-128 encryption core, one round per clock.
// The caller hands in a block with start/in_ready, then supplies round
// key round_num on round_key one cycle after each request. Ciphertexts
// leave as out_valid strobes under credit flow control.

`timescale 1ns/1ps

module aes_cipher_core (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start,
    input  aes_pkg::aes_block_t   plaintext,
    output logic                  in_ready,
    output aes_pkg::round_index_t round_num,
    input  aes_pkg::aes_block_t   round_key,
    output aes_pkg::aes_block_t   ciphertext,
    output logic                  out_valid,
    input  logic                  credit_return
);
    import aes_pkg::*;

    round_ctrl_t round_ctrl;
    logic        slot_claim;
    logic        slot_free;
    logic        result_valid;
    aes_block_t  result;

    aes_round_sequencer sequencer_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (start),
        .in_ready   (in_ready),
        .slot_free  (slot_free),
        .slot_claim (slot_claim),
        .round_num  (round_num),
        .round_ctrl (round_ctrl)
    );

    // Acceptance doubles as the plaintext load
    aes_round_datapath datapath_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .plaintext    (plaintext),
        .start_load   (slot_claim),
        .round_key    (round_key),
        .round_ctrl   (round_ctrl),
        .result_valid (result_valid),
        .result       (result)
    );

    aes_result_buffer result_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .slot_claim    (slot_claim),
        .slot_free     (slot_free),
        .result_valid  (result_valid),
        .result        (result),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .ciphertext    (ciphertext)
    );

endmodule

/* verilog/aes_pkg.sv */
// Shared types and round helpers for the AES-128 cipher core.
// Holds the state union, the round control word sent from the sequencer
// to the datapath, the S-box table and the GF(2^8) column mixing.
// Import it inside module bodies and use scoped names on ports.

`include "aes_cipher_core_settings.svh"

package aes_pkg;

    typedef logic [`AES_BLOCK_BITS-1:0] aes_block_t;

    // Byte 0 is the MSB, bytes run down each column in turn
    typedef union packed {
        logic [0:`AES_BLOCK_BITS/8-1][7:0]  bytes;
        logic [0:`AES_BLOCK_BITS/32-1][31:0] cols;
    } aes_state_u;

    typedef logic [3:0] round_index_t;

    typedef enum logic [1:0] {
        round_init   = 2'd0,
        round_middle = 2'd1,
        round_final  = 2'd2
    } round_kind_e;

    typedef struct packed {
        logic         valid;
        round_kind_e  kind;
        round_index_t index;
    } round_ctrl_t;

    // Forward S-box, entry 0 in the top byte
    localparam logic [0:255][7:0] sbox_table = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] sub_byte(input logic [7:0] b);
        return sbox_table[b];
    endfunction

    // Multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // One MixColumns column, row 0 in the top byte
    function automatic logic [31:0] mix_column(input logic [31:0] col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

endpackage

/* verilog/aes_result_buffer.sv */
// Result buffer of the AES-128 core.
// A small FIFO of finished ciphertexts. A slot is reserved when the
// sequencer accepts a block, so a block in flight always has room here.
// Entries leave one per cycle as an out_valid strobe, each spending one
// of the consumer's credits; credit_return pulses give them back.

`timescale 1ns/1ps

`include "aes_cipher_core_settings.svh"

module aes_result_buffer (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                slot_claim,
    output logic                slot_free,
    input  logic                result_valid,
    input  aes_pkg::aes_block_t result,
    input  logic                credit_return,
    output logic                out_valid,
    output aes_pkg::aes_block_t ciphertext
);
    import aes_pkg::*;

    localparam int fifo_depth  = `AES_RESULT_DEPTH;
    localparam int ptr_bits    = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_bits    = $clog2(fifo_depth + 1);
    localparam int credit_bits = $clog2(`AES_OUT_CREDITS + 1);

    aes_block_t             mem [fifo_depth];
    logic [ptr_bits-1:0]    wr_ptr;
    logic [ptr_bits-1:0]    rd_ptr;
    logic [cnt_bits-1:0]    fill_cnt;
    logic [cnt_bits-1:0]    resv_cnt;
    logic [credit_bits-1:0] credits;

    function automatic logic [ptr_bits-1:0] ptr_inc(input logic [ptr_bits-1:0] p);
        return (p == ptr_bits'(fifo_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // Reserved slots cover both buffered and in-flight blocks
    assign slot_free  = (resv_cnt < cnt_bits'(fifo_depth));
    assign out_valid  = (fill_cnt != '0) && (credits != '0);
    assign ciphertext = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (result_valid)
            mem[wr_ptr] <= result;
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
            resv_cnt <= '0;
            credits  <= credit_bits'(`AES_OUT_CREDITS);
        end
        else
        begin
            if (result_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (out_valid)
                rd_ptr <= ptr_inc(rd_ptr);

            fill_cnt <= fill_cnt + cnt_bits'(result_valid) - cnt_bits'(out_valid);
            resv_cnt <= resv_cnt + cnt_bits'(slot_claim) - cnt_bits'(out_valid);

            // A return and a spend in the same cycle cancel out
            credits <= credits + credit_bits'(credit_return) - credit_bits'(out_valid);
        end
    end

endmodule

/* verilog/aes_round_datapath.sv */
// Round datapath of the AES-128 core.
// Holds the cipher state and applies one round per clock as directed by
// the sequencer's round control. The final round is not stored back;
// its output goes straight to the result buffer with result_valid.

`timescale 1ns/1ps

module aes_round_datapath (
    input  logic                 clk,
    input  logic                 reset_n,
    input  aes_pkg::aes_block_t  plaintext,
    input  logic                 start_load,
    input  aes_pkg::aes_block_t  round_key,
    input  aes_pkg::round_ctrl_t round_ctrl,
    output logic                 result_valid,
    output aes_pkg::aes_block_t  result
);
    import aes_pkg::*;

    aes_block_t plain_q;
    aes_state_u state_q;
    aes_state_u subbed;
    aes_state_u shifted;
    aes_state_u mixed;
    aes_block_t next_state;

    // Plaintext waits here until key 0 arrives
    always_ff @(posedge clk)
    begin
        if (start_load)
            plain_q <= plaintext;
    end

    // SubBytes
    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            subbed.bytes[i] = sub_byte(state_q.bytes[i]);
        end
    end

    // ShiftRows, row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted.bytes[4*c + r] = subbed.bytes[4*((c + r) % 4) + r];
            end
        end
    end

    // MixColumns works on the column view of the same state
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            mixed.cols[c] = mix_column(shifted.cols[c]);
        end
    end

    // AddRoundKey for the rounds that stay in the state register
    always_comb
    begin
        if (round_ctrl.kind == round_init)
            next_state = plain_q ^ round_key;
        else
            next_state = mixed ^ round_key;
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state_q <= '0;
        end
        else if (round_ctrl.valid && (round_ctrl.kind != round_final))
        begin
            state_q <= next_state;
        end
    end

    // Final round skips MixColumns
    assign result       = shifted ^ round_key;
    assign result_valid = round_ctrl.valid && (round_ctrl.kind == round_final);

endmodule

/* verilog/aes_round_sequencer.sv */
// Round sequencer of the AES-128 core.
// Accepts a block when a result slot is free, then walks the round key
// requests 0..AES_ROUNDS on round_num. One cycle later the same count
// reaches the datapath as round control, decoded into its round kind.

`timescale 1ns/1ps

`include "aes_cipher_core_settings.svh"

module aes_round_sequencer (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start,
    output logic                  in_ready,
    input  logic                  slot_free,
    output logic                  slot_claim,
    output aes_pkg::round_index_t round_num,
    output aes_pkg::round_ctrl_t  round_ctrl
);
    import aes_pkg::*;

    typedef enum logic {
        seq_idle,
        seq_run
    } seq_state_e;

    seq_state_e  state;
    logic        last_key;
    round_kind_e kind;

    // Accept only with a result slot reserved for the block
    assign in_ready   = (state == seq_idle) && slot_free;
    assign slot_claim = start && in_ready;
    assign last_key   = (round_num == round_index_t'(`AES_ROUNDS));

    // Key 0 is the plain key add, the last key drops MixColumns
    always_comb
    begin
        if (round_num == '0)
            kind = round_init;
        else if (last_key)
            kind = round_final;
        else
            kind = round_middle;
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state     <= seq_idle;
            round_num <= '0;
        end
        else if (state == seq_idle)
        begin
            if (slot_claim)
                state <= seq_run;
        end
        else
        begin
            if (last_key)
            begin
                state     <= seq_idle;
                round_num <= '0;
            end
            else
            begin
                round_num <= round_num + 1'b1;
            end
        end
    end

    // Trails round_num by a cycle so the caller can register the key
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            round_ctrl <= '0;
        else
        begin
            round_ctrl.valid <= (state == seq_run);
            round_ctrl.kind  <= kind;
            round_ctrl.index <= round_num;
        end
    end

endmodule
